// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_io_subsystem
RTL_TOP   ?= io_subsystem
FILELIST  ?= io_subsystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass line shows up in the simulator output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/flash_model.sv
`default_nettype none

module flash_model (
	input  wire logic spi_sck,
	input  wire logic spi_cs_n,
	input  wire logic spi_mosi,
	output logic      spi_miso
);

	localparam int         HEADER_BITS = 32; // command byte followed by a 24-bit address.
	localparam int         WORD_BITS   = 16;
	localparam logic [7:0] READ_OPCODE = 8'h03;

	logic [HEADER_BITS-1:0] header = '0;
	logic [WORD_BITS-1:0]   word;
	int                     bit_cnt = 0;

	// only a read command gets data back, anything else answers zero.
	assign word = (header[HEADER_BITS-1 -: 8] == READ_OPCODE) ? (header[15:0] ^ 16'hA5C3) : '0;

	initial begin
		spi_miso = 1'b0;
	end

	// a new frame starts when chip select falls.
	always @(negedge spi_cs_n) begin
		bit_cnt <= 0;
	end

	always @(posedge spi_sck) begin
		if (!spi_cs_n) begin
			if (bit_cnt < HEADER_BITS) begin
				header <= {header[HEADER_BITS-2:0], spi_mosi}; // mosi is stable here.
			end
			bit_cnt <= bit_cnt + 1;
		end
	end

	// The word goes out MSB first, one bit per falling edge after the header.
	always @(negedge spi_sck) begin
		if (!spi_cs_n && bit_cnt >= HEADER_BITS && bit_cnt < HEADER_BITS + WORD_BITS) begin
			spi_miso <= word[HEADER_BITS + WORD_BITS - 1 - bit_cnt];
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_io_subsystem.sv
`default_nettype none

module tb_io_subsystem;

	import io_pkg::*;

	localparam int          HALF_PERIOD     = 20;
	localparam int          RESET_CYCLES    = 5;
	localparam int          FRAME_CYCLES    = H_TOTAL * V_TOTAL;
	localparam int          AUDIO_DIV_MIN   = 10; // leaves time to clear before the next sample.
	localparam int          AUDIO_DIV_SPAN  = 30;
	localparam int          SPI_READ_CYCLES = 2 * (SPI_TX_W + FLASH_DATA_BITS) + 4;
	localparam int          TEST_CYCLES     = 2 * FRAME_CYCLES + H_TOTAL
		+ 4 * (AUDIO_DIV_MIN + AUDIO_DIV_SPAN + 1) + 2 * SPI_READ_CYCLES;
	localparam int          WATCHDOG_CYCLES = 3 * TEST_CYCLES;
	localparam logic [31:0] SEED            = 32'h73d6a2a8;

	logic              CLK;
	logic              RSTb;
	logic [ADDR_W-1:0] address;
	logic [DATA_W-1:0] data_in;
	logic [DATA_W-1:0] data_out;
	logic              wr;
	logic              spi_sck;
	logic              spi_cs_n;
	logic              spi_mosi;
	logic              spi_miso;
	logic              hsync;
	logic              vsync;
	logic              interrupt;
	logic [3:0]        irq;

	logic              rd_chk; // a read is compared at the next edge.
	logic [DATA_W-1:0] rd_mask;
	logic [DATA_W-1:0] rd_exp;
	int                frame_pos; // cycle position within a video frame.
	int                cyc;
	logic              int_q;
	logic              audio_chk;
	int                audio_rises;
	int                last_rise;
	int                audio_period;
	int                audio_div;
	logic [15:0]       flash_addr;
	logic [3:0]        ic_pending;
	logic [3:0]        ic_enable;

	io_subsystem io_subsystem_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.address   (address),
		.data_in   (data_in),
		.data_out  (data_out),
		.wr        (wr),
		.spi_sck   (spi_sck),
		.spi_cs_n  (spi_cs_n),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso),
		.hsync     (hsync),
		.vsync     (vsync),
		.interrupt (interrupt),
		.irq       (irq)
	);

	flash_model flash_model_inst (
		.spi_sck  (spi_sck),
		.spi_cs_n (spi_cs_n),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	assign ic_pending = io_subsystem_inst.interrupt_controller_inst.pending;
	assign ic_enable  = io_subsystem_inst.interrupt_controller_inst.enable;

	always #HALF_PERIOD CLK = ~CLK;

	// irq numbers start at 1, so source i reports as i+1.
	function automatic logic [3:0] lowest_source(input logic [3:0] active);
		for (int i = 0; i < IRQ_N; i++) begin
			if (active[i]) begin
				return 4'(i + 1);
			end
		end
		return 4'd0;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		$display("Verification failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] value);
		@(posedge CLK);
		address <= addr;
		data_in <= value;
		wr      <= 1'b1;
		@(posedge CLK);
		wr <= 1'b0;
	endtask

	task automatic expect_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] mask,
		input logic [DATA_W-1:0] value);
		@(posedge CLK);
		address <= addr;
		rd_mask <= mask;
		rd_exp  <= value;
		rd_chk  <= 1'b1;
		@(posedge CLK);
		rd_chk <= 1'b0;
	endtask

	task automatic wait_interrupt();
		do begin
			@(posedge CLK);
		end while (interrupt !== 1'b1);
	endtask

	// reference counters for the video frame and the audio interrupt spacing.
	always @(posedge CLK) begin
		cyc   <= cyc + 1;
		int_q <= interrupt;
		if (!audio_chk) begin
			audio_rises <= 0;
		end else if (interrupt && !int_q) begin
			audio_rises <= audio_rises + 1;
			last_rise   <= cyc;
		end
		if (!RSTb || frame_pos == FRAME_CYCLES - 1) begin
			frame_pos <= 0;
		end else begin
			frame_pos <= frame_pos + 1;
		end
	end

	assert property (@(posedge CLK) disable iff (!RSTb) rd_chk |-> ((data_out & rd_mask) == rd_exp))
		else stop_on_error("register read returned an unexpected value");
	assert property (@(posedge CLK) disable iff (!RSTb)
		irq == lowest_source($past(ic_pending & ic_enable)) && interrupt == (irq != 4'd0))
		else stop_on_error("irq does not follow the pending and enabled sources");
	assert property (@(posedge CLK) disable iff (!RSTb)
		irq == 4'd0 || ((($past(ic_enable) >> (irq - 4'd1)) & 4'd1) != 4'd0))
		else stop_on_error("a disabled source produced its irq number");
	assert property (@(posedge CLK) disable iff (!RSTb) hsync == ((frame_pos % H_TOTAL) < H_SYNC))
		else stop_on_error("hsync level is wrong for the pixel position");
	assert property (@(posedge CLK) disable iff (!RSTb) vsync == (frame_pos < H_TOTAL * V_SYNC))
		else stop_on_error("vsync level is wrong for the line position");
	assert property (@(posedge CLK) disable iff (!RSTb) $rose(vsync) |-> frame_pos == 0)
		else stop_on_error("vsync rose away from the frame start");
	assert property (@(posedge CLK) disable iff (!RSTb) (frame_pos % H_TOTAL) == 1 |-> ic_pending[0])
		else stop_on_error("hsync pending bit not set after a line start");
	assert property (@(posedge CLK) disable iff (!RSTb)
		(audio_chk && interrupt && !int_q && audio_rises != 0) |-> (cyc - last_rise == audio_period))
		else stop_on_error("audio interrupts are not one sample period apart");
	// sck idles low with the chip deselected and toggles every cycle inside a frame.
	assert property (@(posedge CLK) disable iff (!RSTb)
		spi_cs_n ? !spi_sck : ($past(spi_cs_n) || spi_sck != $past(spi_sck)))
		else stop_on_error("spi_sck is not idle low or not running at half the clock rate");

	initial begin
		watchdog_expired: begin
			repeat (WATCHDOG_CYCLES) @(posedge CLK);
			$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
			$display("Verification failed");
			$fatal(1, "watchdog expired");
		end
	end

	initial begin
		CLK          = 1'b0;
		RSTb         = 1'b0;
		address      = '0;
		data_in      = '0;
		wr           = 1'b0;
		rd_chk       = 1'b0;
		rd_mask      = '0;
		rd_exp       = '0;
		frame_pos    = 0;
		cyc          = 0;
		int_q        = 1'b0;
		audio_chk    = 1'b0;
		audio_rises  = 0;
		last_rise    = 0;
		audio_period = 0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(posedge CLK);
		RSTb    <= 1'b1;
		address <= {BLK_IRQ, 4'h2}; // pending is read before the first line start lands.
		rd_mask <= '1;
		rd_exp  <= '0;
		rd_chk  <= 1'b1;
		@(posedge CLK);
		rd_chk <= 1'b0;
		expect_read({BLK_IRQ, 4'h0}, '1, '0);

		// Video with every source enabled, then with hsync masked.
		write_reg({BLK_IRQ, 4'h0}, 16'h000F);
		repeat (FRAME_CYCLES) @(posedge CLK);
		write_reg({BLK_IRQ, 4'h0}, 16'h000E);
		write_reg({BLK_IRQ, 4'h1}, 16'h000F);
		repeat (H_TOTAL) @(posedge CLK);
		expect_read({BLK_IRQ, 4'h2}, 16'h0001, 16'h0001);
		repeat (FRAME_CYCLES) @(posedge CLK);

		// audio alone, cleared after every sample.
		audio_div = AUDIO_DIV_MIN + int'($urandom % AUDIO_DIV_SPAN);
		write_reg({BLK_IRQ, 4'h0}, 16'h0004);
		write_reg({BLK_IRQ, 4'h1}, 16'h000F);
		write_reg({BLK_AUDIO, 4'h0}, DATA_W'(audio_div));
		audio_period <= audio_div + 1;
		write_reg({BLK_AUDIO, 4'h1}, 16'h0001);
		audio_chk <= 1'b1;
		repeat (3) begin
			wait_interrupt();
			write_reg({BLK_IRQ, 4'h1}, 16'h0004);
			expect_read({BLK_IRQ, 4'h2}, 16'h0004, 16'h0000);
		end
		audio_chk <= 1'b0;
		write_reg({BLK_AUDIO, 4'h1}, 16'h0000);

		// Two flash reads at random addresses.
		write_reg({BLK_IRQ, 4'h0}, 16'h0008);
		repeat (2) begin
			flash_addr = 16'($urandom);
			write_reg({BLK_IRQ, 4'h1}, 16'h000F);
			write_reg({BLK_SPI, 4'h0}, flash_addr);
			write_reg({BLK_SPI, 4'h1}, 16'h0001);
			expect_read({BLK_SPI, 4'h1}, 16'h0001, 16'h0001);
			write_reg({BLK_SPI, 4'h1}, 16'h0001); // lands while busy.
			wait_interrupt();
			expect_read({BLK_SPI, 4'h1}, 16'h0001, 16'h0000);
			expect_read({BLK_SPI, 4'h2}, '1, flash_addr ^ 16'hA5C3);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: io_subsystem.f
source/io_pkg.sv
source/io_bus_decode.sv
source/video_timing.sv
source/audio_sample_timer.sv
source/spi_flash_reader.sv
source/interrupt_controller.sv
source/io_subsystem.sv
bench/flash_model.sv
bench/tb_io_subsystem.sv

// File: source/audio_sample_timer.sv
`default_nettype none

module audio_sample_timer (
	input  wire logic                      CLK,
	input  wire logic                      RSTb,
	input  wire logic [3:0]                reg_addr,
	input  wire logic                      wr,
	input  wire logic [io_pkg::DATA_W-1:0] data_in,
	output logic      [io_pkg::DATA_W-1:0] rdata,
	output logic                           irq_audio
);

	import io_pkg::*;

	logic [DATA_W-1:0] divider;
	logic              enable;
	logic [DATA_W-1:0] count;

	// register writes.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			divider <= '0;
			enable  <= 1'b0;
		end else if (wr) begin
			if (reg_addr == 4'h0) begin
				divider <= data_in;
			end
			if (reg_addr == 4'h1) begin
				enable <= data_in[0];
			end
		end
	end

	// The counter runs from the divider down to zero, so one period is divider+1 cycles.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			count     <= '0;
			irq_audio <= 1'b0;
		end else begin
			irq_audio <= enable && (count == '0);
			if (!enable || count == '0) begin
				count <= divider; // a stopped timer sits preloaded.
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	always_comb begin
		case (reg_addr)
			4'h0:    rdata = divider;
			4'h1:    rdata = {{(DATA_W - 1){1'b0}}, enable};
			4'h2:    rdata = count;
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/interrupt_controller.sv
`default_nettype none

module interrupt_controller (
	input  wire logic                      CLK,
	input  wire logic                      RSTb,
	input  wire logic [3:0]                reg_addr,
	input  wire logic                      wr,
	input  wire logic [io_pkg::DATA_W-1:0] data_in,
	input  wire logic                      irq_hsync,
	input  wire logic                      irq_vsync,
	input  wire logic                      irq_audio,
	input  wire logic                      irq_spi,
	output logic      [io_pkg::DATA_W-1:0] rdata,
	output logic                           interrupt,
	output logic      [3:0]                irq
);

	import io_pkg::*;

	logic [IRQ_N-1:0] enable;
	logic [IRQ_N-1:0] pending;
	logic [IRQ_N-1:0] irq_in;
	logic [IRQ_N-1:0] clear_mask;
	logic [IRQ_N-1:0] pend_en;
	logic [3:0]       irq_next;

	// bit 0 has the highest priority.
	assign irq_in = {irq_spi, irq_audio, irq_vsync, irq_hsync};

	// A clear is applied at the same edge that captures the write.
	assign clear_mask = (wr && reg_addr == 4'h1) ? data_in[IRQ_N-1:0] : '0;
	assign pend_en    = pending & enable;

	// Scan from the lowest priority up so the lowest index is left standing.
	always_comb begin
		irq_next = 4'd0;
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (pend_en[i]) begin
				irq_next = 4'(i + 1);
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			enable    <= '0;
			pending   <= '0;
			irq       <= 4'd0;
			interrupt <= 1'b0;
		end else begin
			if (wr && reg_addr == 4'h0) begin
				enable <= data_in[IRQ_N-1:0];
			end
			pending   <= (pending & ~clear_mask) | irq_in; // a fresh pulse beats a clear.
			irq       <= irq_next;
			interrupt <= (irq_next != 4'd0);
		end
	end

	// The clear register is write-only and reads back as zero.
	always_comb begin
		case (reg_addr)
			4'h0: begin
				rdata = {{(DATA_W - IRQ_N){1'b0}}, enable};
			end
			4'h2: begin
				rdata = {{(DATA_W - IRQ_N){1'b0}}, pending};
			end
			default: begin
				rdata = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/io_bus_decode.sv
`default_nettype none

module io_bus_decode (
	input  wire logic [io_pkg::ADDR_W-1:0] address,
	input  wire logic                      wr,
	input  wire logic [io_pkg::DATA_W-1:0] irq_rdata,
	input  wire logic [io_pkg::DATA_W-1:0] audio_rdata,
	input  wire logic [io_pkg::DATA_W-1:0] spi_rdata,
	input  wire logic [io_pkg::DATA_W-1:0] video_rdata,
	output logic      [3:0]                reg_addr,
	output logic                           irq_wr,
	output logic                           audio_wr,
	output logic                           spi_wr,
	output logic                           video_wr,
	output logic      [io_pkg::DATA_W-1:0] data_out
);

	import io_pkg::*;

	logic [3:0] blk;

	assign blk      = address[ADDR_W-1:4];
	assign reg_addr = address[3:0]; // every block sees the same register offset.

	// Only one strobe can be high, since the block codes are distinct.
	assign irq_wr   = wr && (blk == BLK_IRQ);
	assign audio_wr = wr && (blk == BLK_AUDIO);
	assign spi_wr   = wr && (blk == BLK_SPI);
	assign video_wr = wr && (blk == BLK_VIDEO);

	// Reads complete in the same cycle, so this mux is purely combinational.
	always_comb begin
		case (blk)
			BLK_IRQ: begin
				data_out = irq_rdata;
			end
			BLK_AUDIO: begin
				data_out = audio_rdata;
			end
			BLK_SPI: begin
				data_out = spi_rdata;
			end
			BLK_VIDEO: begin
				data_out = video_rdata;
			end
			default: begin
				data_out = '0; // unmapped blocks read as zero.
			end
		endcase
	end

endmodule

`default_nettype wire

// File: source/io_pkg.sv
`default_nettype none

package io_pkg;

	// register port widths.
	localparam int DATA_W = 16;
	localparam int ADDR_W = 8; // upper nibble is the block, lower nibble the register.

	// block select codes on address[7:4].
	localparam logic [3:0] BLK_IRQ   = 4'd0;
	localparam logic [3:0] BLK_AUDIO = 4'd1;
	localparam logic [3:0] BLK_SPI   = 4'd2;
	localparam logic [3:0] BLK_VIDEO = 4'd3;

	// Video timing, in pixels per line and lines per frame.
	localparam int H_TOTAL = 64;
	localparam int H_SYNC  = 8;
	localparam int V_TOTAL = 16;
	localparam int V_SYNC  = 2;
	localparam int H_CNT_W = $clog2(H_TOTAL);
	localparam int V_CNT_W = $clog2(V_TOTAL);

	localparam int IRQ_N = 4; // hsync, vsync, audio, spi in priority order.

	// The SPI read frame is a command byte, three address bytes, then one data word.
	localparam int FLASH_CMD_BITS  = 8;
	localparam int FLASH_ADDR_BITS = 24;
	localparam int FLASH_DATA_BITS = 16;
	localparam int SPI_TX_W  = FLASH_CMD_BITS + FLASH_ADDR_BITS;
	localparam int SPI_CNT_W = $clog2(SPI_TX_W + FLASH_DATA_BITS);

	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_CMD,
		SPI_ADDR,
		SPI_DATA,
		SPI_DONE
	} spi_state_t;

	// only the plain read opcode is issued by this design.
	typedef enum logic [7:0] {
		FLASH_READ = 8'h03
	} flash_cmd_t;

endpackage

`default_nettype wire

// File: source/io_subsystem.sv
`default_nettype none

module io_subsystem (
	input  wire logic                      CLK,
	input  wire logic                      RSTb,
	input  wire logic [io_pkg::ADDR_W-1:0] address,
	input  wire logic [io_pkg::DATA_W-1:0] data_in,
	output logic      [io_pkg::DATA_W-1:0] data_out,
	input  wire logic                      wr,
	output logic                           spi_sck,
	output logic                           spi_cs_n,
	output logic                           spi_mosi,
	input  wire logic                      spi_miso,
	output logic                           hsync,
	output logic                           vsync,
	output logic                           interrupt,
	output logic      [3:0]                irq
);

	import io_pkg::*;

	logic [3:0]        reg_addr;
	logic              irq_wr;
	logic              audio_wr;
	logic              spi_wr;
	logic [DATA_W-1:0] irq_rdata;
	logic [DATA_W-1:0] audio_rdata;
	logic [DATA_W-1:0] spi_rdata;
	logic [DATA_W-1:0] video_rdata;
	logic              irq_hsync;
	logic              irq_vsync;
	logic              irq_audio;
	logic              irq_spi;

	// video has no writable registers, so its strobe is left open.
	io_bus_decode io_bus_decode_inst (
		.address     (address),
		.wr          (wr),
		.irq_rdata   (irq_rdata),
		.audio_rdata (audio_rdata),
		.spi_rdata   (spi_rdata),
		.video_rdata (video_rdata),
		.reg_addr    (reg_addr),
		.irq_wr      (irq_wr),
		.audio_wr    (audio_wr),
		.spi_wr      (spi_wr),
		.video_wr    (),
		.data_out    (data_out)
	);

	video_timing video_timing_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.hsync     (hsync),
		.vsync     (vsync),
		.irq_hsync (irq_hsync),
		.irq_vsync (irq_vsync),
		.rdata     (video_rdata)
	);

	audio_sample_timer audio_sample_timer_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.reg_addr  (reg_addr),
		.wr        (audio_wr),
		.data_in   (data_in),
		.rdata     (audio_rdata),
		.irq_audio (irq_audio)
	);

	spi_flash_reader spi_flash_reader_inst (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.reg_addr (reg_addr),
		.wr       (spi_wr),
		.data_in  (data_in),
		.spi_miso (spi_miso),
		.rdata    (spi_rdata),
		.irq_spi  (irq_spi),
		.spi_sck  (spi_sck),
		.spi_cs_n (spi_cs_n),
		.spi_mosi (spi_mosi)
	);

	interrupt_controller interrupt_controller_inst (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.reg_addr  (reg_addr),
		.wr        (irq_wr),
		.data_in   (data_in),
		.irq_hsync (irq_hsync),
		.irq_vsync (irq_vsync),
		.irq_audio (irq_audio),
		.irq_spi   (irq_spi),
		.rdata     (irq_rdata),
		.interrupt (interrupt),
		.irq       (irq)
	);

endmodule

`default_nettype wire

// File: source/spi_flash_reader.sv
`default_nettype none

module spi_flash_reader (
	input  wire logic                      CLK,
	input  wire logic                      RSTb,
	input  wire logic [3:0]                reg_addr,
	input  wire logic                      wr,
	input  wire logic [io_pkg::DATA_W-1:0] data_in,
	input  wire logic                      spi_miso,
	output logic      [io_pkg::DATA_W-1:0] rdata,
	output logic                           irq_spi,
	output logic                           spi_sck,
	output logic                           spi_cs_n,
	output logic                           spi_mosi
);

	import io_pkg::*;

	spi_state_t           state;
	logic                 sck;
	logic                 cs_n;
	logic [SPI_CNT_W-1:0] bit_cnt; // counts every bit of the frame, command through data.
	logic [DATA_W-1:0]    flash_addr;
	logic [SPI_TX_W-1:0]  tx_shift;
	logic [DATA_W-1:0]    rx_data;
	logic                 start;
	logic                 busy;
	logic                 shifting;

	assign start    = wr && (reg_addr == 4'h1) && data_in[0];
	assign shifting = state inside {SPI_CMD, SPI_ADDR, SPI_DATA};
	assign busy     = shifting; // busy is already low in the done cycle.

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state      <= SPI_IDLE;
			sck        <= 1'b0;
			cs_n       <= 1'b1;
			bit_cnt    <= '0;
			flash_addr <= '0;
		end else begin
			if (wr && reg_addr == 4'h0) begin
				flash_addr <= data_in;
			end
			case (state)
				SPI_IDLE: begin
					if (start) begin // a start while busy never reaches here.
						state   <= SPI_CMD;
						cs_n    <= 1'b0;
						bit_cnt <= '0;
					end
				end
				SPI_CMD, SPI_ADDR, SPI_DATA: begin
					sck <= ~sck;
					// Each bit ends on the falling edge of sck.
					if (sck) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == SPI_CNT_W'(FLASH_CMD_BITS - 1)) begin
							state <= SPI_ADDR;
						end else if (bit_cnt == SPI_CNT_W'(SPI_TX_W - 1)) begin
							state <= SPI_DATA;
						end else if (bit_cnt == SPI_CNT_W'(SPI_TX_W + FLASH_DATA_BITS - 1)) begin
							state <= SPI_DONE;
							cs_n  <= 1'b1;
						end
					end
				end
				SPI_DONE: begin
					state <= SPI_IDLE;
				end
				default: begin
					state <= SPI_IDLE;
				end
			endcase
		end
	end

	// The command and the address leave MSB first, and mosi moves with the falling edge.
	always_ff @(posedge CLK) begin
		if (state == SPI_IDLE && start) begin
			tx_shift <= {FLASH_READ, {(FLASH_ADDR_BITS - DATA_W){1'b0}}, flash_addr};
		end else if (shifting && sck) begin
			tx_shift <= {tx_shift[SPI_TX_W-2:0], 1'b0};
		end
		// miso is captured as sck rises.
		if (state == SPI_DATA && !sck) begin
			rx_data <= {rx_data[DATA_W-2:0], spi_miso};
		end
	end

	assign spi_sck  = sck;
	assign spi_cs_n = cs_n;
	assign spi_mosi = tx_shift[SPI_TX_W-1];
	assign irq_spi  = (state == SPI_DONE);

	always_comb begin
		case (reg_addr)
			4'h0:    rdata = flash_addr;
			4'h1:    rdata = {{(DATA_W - 1){1'b0}}, busy};
			4'h2:    rdata = rx_data;
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/video_timing.sv
`default_nettype none

module video_timing (
	input  wire logic                      CLK,
	input  wire logic                      RSTb,
	output logic                           hsync,
	output logic                           vsync,
	output logic                           irq_hsync,
	output logic                           irq_vsync,
	output logic      [io_pkg::DATA_W-1:0] rdata
);

	import io_pkg::*;

	logic [H_CNT_W-1:0] pixel;
	logic [V_CNT_W-1:0] line;
	logic               line_end;

	assign line_end = (pixel == H_CNT_W'(H_TOTAL - 1));

	// pixel counter wraps every line, line counter wraps every frame.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pixel <= '0;
			line  <= '0;
		end else begin
			if (line_end) begin
				pixel <= '0;
				if (line == V_CNT_W'(V_TOTAL - 1)) begin
					line <= '0;
				end else begin
					line <= line + 1'b1;
				end
			end else begin
				pixel <= pixel + 1'b1;
			end
		end
	end

	assign hsync = (pixel < H_CNT_W'(H_SYNC)); // sync at the start of each line.
	assign vsync = (line < V_CNT_W'(V_SYNC));

	// The interrupt pulses mark the first pixel of a line and of a frame.
	assign irq_hsync = (pixel == '0);
	assign irq_vsync = (pixel == '0) && (line == '0);

	// The CPU can poll which line is being scanned.
	assign rdata = {{(DATA_W - V_CNT_W){1'b0}}, line};

endmodule

`default_nettype wire
